//--- logic/iq_cfg_pkg.sv
// ==================================================
// issue queue geometry shared by the design.
// ==================================================
`default_nettype none

package iq_cfg_pkg;

    // default number of queue slots.
    parameter int IQ_DEPTH = 12;

    // physical register tag and ROB id widths.
    parameter int TAG_W = 6;
    parameter int ROB_W = 6;

    // execution units that broadcast wakeups.
    parameter int NUM_WAKE = 3;

endpackage

`default_nettype wire

//--- logic/iq_types_pkg.sv
// ==================================================
// issue queue field types.
// ==================================================
`default_nettype none

package iq_types_pkg;

    import iq_cfg_pkg::*;

    // source physical register tag.
    typedef logic [TAG_W-1:0] phys_tag_t;

    // reorder buffer id carried to the execution units.
    typedef logic [ROB_W-1:0] rob_id_t;

endpackage

`default_nettype wire

//--- logic/wakeup_if.sv
// ==================================================
// wakeup buses from the execution units.
// ==================================================
`timescale 1ns/1ps
`default_nettype none

interface wakeup_if
    import iq_cfg_pkg::*;
    import iq_types_pkg::*;
();

    // one tag per unit, valid for a single cycle.
    phys_tag_t [NUM_WAKE-1:0] tag;
    logic      [NUM_WAKE-1:0] vld;

    modport src (
        output tag,
        output vld
    );

    modport snk (
        input tag,
        input vld
    );

endinterface

`default_nettype wire

//--- logic/dispatch_if.sv
// ==================================================
// one dispatch port into the issue queue.
// ==================================================
`timescale 1ns/1ps
`default_nettype none

interface dispatch_if
    import iq_types_pkg::*;
();

    logic      vld;
    logic      branch;
    phys_tag_t rs1_tag;
    phys_tag_t rs2_tag;
    rob_id_t   rob;
    // used: the source is read; rdy: it was produced before dispatch.
    logic      rs1_used;
    logic      rs2_used;
    logic      rs1_rdy;
    logic      rs2_rdy;

    modport src (
        output vld, branch, rs1_tag, rs2_tag, rob,
        output rs1_used, rs2_used, rs1_rdy, rs2_rdy
    );

    modport snk (
        input vld, branch, rs1_tag, rs2_tag, rob,
        input rs1_used, rs2_used, rs1_rdy, rs2_rdy
    );

endinterface

`default_nettype wire

//--- logic/iq_compact_ctrl.sv
// ==================================================
// issue queue collapse control.
// per-slot shift amounts and dispatch busy levels.
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module iq_compact_ctrl
    import iq_cfg_pkg::*;
#(
    parameter int DEPTH = IQ_DEPTH
) (
    input  wire logic [DEPTH-1:0] slot_vld_i,
    output logic      [DEPTH-1:0] shift1_o,
    output logic      [DEPTH-1:0] shift2_o,
    output logic                  p0_busy_o,
    output logic                  p1_busy_o
);

    logic [DEPTH-1:0] one_free;
    logic [DEPTH-1:0] two_free;

    always_comb begin
        // a free slot at or below i.
        one_free[0] = ~slot_vld_i[0];
        for (int i = 1; i < DEPTH; i++) begin
            one_free[i] = one_free[i-1] | ~slot_vld_i[i];
        end

        // slot i+1 free while another one sits at or below i.
        two_free[0] = ~slot_vld_i[1] & one_free[0];
        for (int i = 1; i < DEPTH - 1; i++) begin
            two_free[i] = two_free[i-1] | (~slot_vld_i[i+1] & one_free[i]);
        end

        // top slot sees the same two holes as the slot below it.
        two_free[DEPTH-1] = two_free[DEPTH-2];
    end

    assign shift1_o = one_free;
    assign shift2_o = two_free;

    // top slot decides how many dispatches are taken.
    assign p0_busy_o = ~one_free[DEPTH-1];
    assign p1_busy_o = ~two_free[DEPTH-1];

endmodule

`default_nettype wire

//--- logic/iq_src_capture.sv
// ==================================================
// source readiness of the two dispatched micro-ops.
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module iq_src_capture
    import iq_cfg_pkg::*;
    import iq_types_pkg::*;
(
    wakeup_if.snk   wake,
    dispatch_if.snk p0,
    dispatch_if.snk p1,
    output logic    p0_av1_o,
    output logic    p0_av2_o,
    output logic    p1_av1_o,
    output logic    p1_av2_o
);

    // true when any unit broadcasts this tag now.
    function automatic logic tag_hit(input phys_tag_t tag);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < NUM_WAKE; w++) begin
            hit = hit | (wake.vld[w] & (wake.tag[w] == tag));
        end
        return hit;
    endfunction

    // unused sources count as ready.
    assign p0_av1_o = ~p0.rs1_used | p0.rs1_rdy | tag_hit(p0.rs1_tag);
    assign p0_av2_o = ~p0.rs2_used | p0.rs2_rdy | tag_hit(p0.rs2_tag);
    assign p1_av1_o = ~p1.rs1_used | p1.rs1_rdy | tag_hit(p1.rs1_tag);
    assign p1_av2_o = ~p1.rs2_used | p1.rs2_rdy | tag_hit(p1.rs2_tag);

endmodule

`default_nettype wire

//--- logic/iq_entry_array.sv
// ==================================================
// issue queue slot storage, age ordered.
// wakeup match, issue removal, collapse and insert.
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module iq_entry_array
    import iq_cfg_pkg::*;
    import iq_types_pkg::*;
#(
    parameter int DEPTH = IQ_DEPTH
) (
    input  wire logic             cpu_clk_i,
    input  wire logic             rst_n_i,
    input  wire logic             flush_i,
    wakeup_if.snk                 wake,
    dispatch_if.snk               p0,
    dispatch_if.snk               p1,
    input  wire logic             p0_av1_i,
    input  wire logic             p0_av2_i,
    input  wire logic             p1_av1_i,
    input  wire logic             p1_av2_i,
    input  wire logic [DEPTH-1:0] shift1_i,
    input  wire logic [DEPTH-1:0] shift2_i,
    input  wire logic [DEPTH-1:0] grant0_i,
    input  wire logic [DEPTH-1:0] grant1_i,
    output logic      [DEPTH-1:0] slot_vld_o,
    output logic      [DEPTH-1:0] slot_rdy_o,
    output logic      [DEPTH-1:0] slot_branch_o,
    output phys_tag_t [DEPTH-1:0] rs1_tag_o,
    output phys_tag_t [DEPTH-1:0] rs2_tag_o,
    output rob_id_t   [DEPTH-1:0] rob_o
);

    // branch, two ready bits, two tags and the ROB id.
    localparam int ENT_W = 3 + 2 * TAG_W + ROB_W;

    logic [DEPTH-1:0]            vld_q;
    logic [DEPTH-1:0]            av1_q;
    logic [DEPTH-1:0]            av2_q;
    logic [DEPTH-1:0][ENT_W-1:0] ent_q;

    // slots after wakeup and removal, with p0 and p1 stacked on top.
    logic [DEPTH+1:0]            vld_x;
    logic [DEPTH+1:0][ENT_W-1:0] ent_x;
    logic [DEPTH-1:0]            vld_d;
    logic [DEPTH-1:0][ENT_W-1:0] ent_d;

    function automatic logic tag_hit(input phys_tag_t tag);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < NUM_WAKE; w++) begin
            hit = hit | (wake.vld[w] & (wake.tag[w] == tag));
        end
        return hit;
    endfunction

    for (genvar i = 0; i < DEPTH; i++) begin : g_unpack
        assign {slot_branch_o[i], av1_q[i], av2_q[i], rs1_tag_o[i], rs2_tag_o[i], rob_o[i]} =
            ent_q[i];
    end

    assign slot_vld_o = vld_q;
    assign slot_rdy_o = vld_q & av1_q & av2_q;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            vld_x[i] = vld_q[i] & ~grant0_i[i] & ~grant1_i[i] & ~flush_i;
            ent_x[i] = {slot_branch_o[i],
                        av1_q[i] | tag_hit(rs1_tag_o[i]),
                        av2_q[i] | tag_hit(rs2_tag_o[i]),
                        rs1_tag_o[i], rs2_tag_o[i], rob_o[i]};
        end

        // p1 is younger, so it lands above p0.
        vld_x[DEPTH]   = p0.vld & ~flush_i;
        vld_x[DEPTH+1] = p1.vld & ~flush_i;
        ent_x[DEPTH]   = {p0.branch, p0_av1_i, p0_av2_i, p0.rs1_tag, p0.rs2_tag, p0.rob};
        ent_x[DEPTH+1] = {p1.branch, p1_av1_i, p1_av2_i, p1.rs1_tag, p1.rs2_tag, p1.rob};

        // each slot pulls from zero, one or two positions above.
        for (int i = 0; i < DEPTH; i++) begin
            if (shift2_i[i]) begin
                vld_d[i] = vld_x[i+2];
                ent_d[i] = ent_x[i+2];
            end else if (shift1_i[i]) begin
                vld_d[i] = vld_x[i+1];
                ent_d[i] = ent_x[i+1];
            end else begin
                vld_d[i] = vld_x[i];
                ent_d[i] = ent_x[i];
            end
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= vld_d;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        ent_q <= ent_d;
    end

endmodule

`default_nettype wire

//--- logic/iq_issue_select.sv
// ==================================================
// oldest-first pickers for the two ALU issue ports.
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module iq_issue_select
    import iq_cfg_pkg::*;
    import iq_types_pkg::*;
#(
    parameter int DEPTH = IQ_DEPTH
) (
    input  wire logic                  cpu_clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  flush_i,
    input  wire logic      [DEPTH-1:0] slot_rdy_i,
    input  wire logic      [DEPTH-1:0] slot_branch_i,
    input  wire phys_tag_t [DEPTH-1:0] rs1_tag_i,
    input  wire phys_tag_t [DEPTH-1:0] rs2_tag_i,
    input  wire rob_id_t   [DEPTH-1:0] rob_i,
    output logic           [DEPTH-1:0] grant0_o,
    output logic           [DEPTH-1:0] grant1_o,
    output logic                       alu0_vld_o,
    output phys_tag_t                  alu0_rs1_o,
    output phys_tag_t                  alu0_rs2_o,
    output rob_id_t                    alu0_rob_o,
    output logic                       alu1_vld_o,
    output phys_tag_t                  alu1_rs1_o,
    output phys_tag_t                  alu1_rs2_o,
    output rob_id_t                    alu1_rob_o
);

    logic [DEPTH-1:0] second_rdy;
    phys_tag_t        sel0_rs1;
    phys_tag_t        sel0_rs2;
    rob_id_t          sel0_rob;
    phys_tag_t        sel1_rs1;
    phys_tag_t        sel1_rs2;
    rob_id_t          sel1_rob;

    // lowest set bit, slot 0 being the oldest.
    function automatic logic [DEPTH-1:0] oldest(input logic [DEPTH-1:0] req);
        return req & (~req + 1'b1);
    endfunction

    // alu1 never takes a branch.
    assign second_rdy = slot_rdy_i & ~grant0_o & ~slot_branch_i;
    assign grant0_o   = oldest(slot_rdy_i);
    assign grant1_o   = oldest(second_rdy);

    always_comb begin
        sel0_rs1 = '0;
        sel0_rs2 = '0;
        sel0_rob = '0;
        sel1_rs1 = '0;
        sel1_rs2 = '0;
        sel1_rob = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (grant0_o[i]) begin
                sel0_rs1 = rs1_tag_i[i];
                sel0_rs2 = rs2_tag_i[i];
                sel0_rob = rob_i[i];
            end
            if (grant1_o[i]) begin
                sel1_rs1 = rs1_tag_i[i];
                sel1_rs2 = rs2_tag_i[i];
                sel1_rob = rob_i[i];
            end
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i) begin
            alu0_vld_o <= 1'b0;
            alu1_vld_o <= 1'b0;
        end else begin
            alu0_vld_o <= (|grant0_o) & ~flush_i;
            alu1_vld_o <= (|grant1_o) & ~flush_i;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        alu0_rs1_o <= sel0_rs1;
        alu0_rs2_o <= sel0_rs2;
        alu0_rob_o <= sel0_rob;
        alu1_rs1_o <= sel1_rs1;
        alu1_rs2_o <= sel1_rs2;
        alu1_rob_o <= sel1_rob;
    end

endmodule

`default_nettype wire

//--- logic/int_issue_queue.sv
// ==================================================
// unified integer issue queue, two-wide dispatch
// and two ALU issue ports.
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module int_issue_queue
    import iq_cfg_pkg::*;
    import iq_types_pkg::*;
#(
    parameter int DEPTH = IQ_DEPTH
) (
    input  wire logic      cpu_clk_i,
    input  wire logic      rst_n_i,
    input  wire logic      flush_i,
    input  wire logic      p0_vld_i,
    input  wire logic      p0_branch_i,
    input  wire phys_tag_t p0_rs1_tag_i,
    input  wire phys_tag_t p0_rs2_tag_i,
    input  wire rob_id_t   p0_rob_i,
    input  wire logic      p0_rs1_vld_i,
    input  wire logic      p0_rs2_vld_i,
    input  wire logic      p0_rs1_rdy_i,
    input  wire logic      p0_rs2_rdy_i,
    input  wire logic      p1_vld_i,
    input  wire logic      p1_branch_i,
    input  wire phys_tag_t p1_rs1_tag_i,
    input  wire phys_tag_t p1_rs2_tag_i,
    input  wire rob_id_t   p1_rob_i,
    input  wire logic      p1_rs1_vld_i,
    input  wire logic      p1_rs2_vld_i,
    input  wire logic      p1_rs1_rdy_i,
    input  wire logic      p1_rs2_rdy_i,
    input  wire phys_tag_t eu0_wk_i,
    input  wire phys_tag_t eu1_wk_i,
    input  wire phys_tag_t eu2_wk_i,
    input  wire logic      eu0_vld_i,
    input  wire logic      eu1_vld_i,
    input  wire logic      eu2_vld_i,
    output logic           p0_busy_o,
    output logic           p1_busy_o,
    output logic           alu0_vld_o,
    output phys_tag_t      alu0_rs1_o,
    output phys_tag_t      alu0_rs2_o,
    output rob_id_t        alu0_rob_o,
    output logic           alu1_vld_o,
    output phys_tag_t      alu1_rs1_o,
    output phys_tag_t      alu1_rs2_o,
    output rob_id_t        alu1_rob_o
);

    logic      [DEPTH-1:0] slot_vld;
    logic      [DEPTH-1:0] slot_rdy;
    logic      [DEPTH-1:0] slot_branch;
    logic      [DEPTH-1:0] shift1;
    logic      [DEPTH-1:0] shift2;
    logic      [DEPTH-1:0] grant0;
    logic      [DEPTH-1:0] grant1;
    phys_tag_t [DEPTH-1:0] rs1_tag;
    phys_tag_t [DEPTH-1:0] rs2_tag;
    rob_id_t   [DEPTH-1:0] rob;
    logic                  p0_av1;
    logic                  p0_av2;
    logic                  p1_av1;
    logic                  p1_av2;

    wakeup_if   wake ();
    dispatch_if p0 ();
    dispatch_if p1 ();

    assign wake.tag = {eu2_wk_i, eu1_wk_i, eu0_wk_i};
    assign wake.vld = {eu2_vld_i, eu1_vld_i, eu0_vld_i};

    assign p0.vld      = p0_vld_i;
    assign p0.branch   = p0_branch_i;
    assign p0.rs1_tag  = p0_rs1_tag_i;
    assign p0.rs2_tag  = p0_rs2_tag_i;
    assign p0.rob      = p0_rob_i;
    assign p0.rs1_used = p0_rs1_vld_i;
    assign p0.rs2_used = p0_rs2_vld_i;
    assign p0.rs1_rdy  = p0_rs1_rdy_i;
    assign p0.rs2_rdy  = p0_rs2_rdy_i;

    assign p1.vld      = p1_vld_i;
    assign p1.branch   = p1_branch_i;
    assign p1.rs1_tag  = p1_rs1_tag_i;
    assign p1.rs2_tag  = p1_rs2_tag_i;
    assign p1.rob      = p1_rob_i;
    assign p1.rs1_used = p1_rs1_vld_i;
    assign p1.rs2_used = p1_rs2_vld_i;
    assign p1.rs1_rdy  = p1_rs1_rdy_i;
    assign p1.rs2_rdy  = p1_rs2_rdy_i;

    iq_compact_ctrl #(.DEPTH(DEPTH)) i_iq_compact_ctrl (
        .slot_vld_i (slot_vld),
        .shift1_o   (shift1),
        .shift2_o   (shift2),
        .p0_busy_o  (p0_busy_o),
        .p1_busy_o  (p1_busy_o)
    );

    iq_src_capture i_iq_src_capture (
        .wake     (wake),
        .p0       (p0),
        .p1       (p1),
        .p0_av1_o (p0_av1),
        .p0_av2_o (p0_av2),
        .p1_av1_o (p1_av1),
        .p1_av2_o (p1_av2)
    );

    iq_entry_array #(.DEPTH(DEPTH)) i_iq_entry_array (
        .cpu_clk_i     (cpu_clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .wake          (wake),
        .p0            (p0),
        .p1            (p1),
        .p0_av1_i      (p0_av1),
        .p0_av2_i      (p0_av2),
        .p1_av1_i      (p1_av1),
        .p1_av2_i      (p1_av2),
        .shift1_i      (shift1),
        .shift2_i      (shift2),
        .grant0_i      (grant0),
        .grant1_i      (grant1),
        .slot_vld_o    (slot_vld),
        .slot_rdy_o    (slot_rdy),
        .slot_branch_o (slot_branch),
        .rs1_tag_o     (rs1_tag),
        .rs2_tag_o     (rs2_tag),
        .rob_o         (rob)
    );

    iq_issue_select #(.DEPTH(DEPTH)) i_iq_issue_select (
        .cpu_clk_i     (cpu_clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .slot_rdy_i    (slot_rdy),
        .slot_branch_i (slot_branch),
        .rs1_tag_i     (rs1_tag),
        .rs2_tag_i     (rs2_tag),
        .rob_i         (rob),
        .grant0_o      (grant0),
        .grant1_o      (grant1),
        .alu0_vld_o    (alu0_vld_o),
        .alu0_rs1_o    (alu0_rs1_o),
        .alu0_rs2_o    (alu0_rs2_o),
        .alu0_rob_o    (alu0_rob_o),
        .alu1_vld_o    (alu1_vld_o),
        .alu1_rs1_o    (alu1_rs1_o),
        .alu1_rs2_o    (alu1_rs2_o),
        .alu1_rob_o    (alu1_rob_o)
    );

endmodule

`default_nettype wire

//--- tests/tb_int_issue_queue.sv
// ==================================================
// self-checking testbench for the integer issue queue.
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module tb_int_issue_queue
    import iq_cfg_pkg::*;
    import iq_types_pkg::*;
();

    localparam int DEPTH    = IQ_DEPTH;
    localparam int WAIT_MAX = 40;

    typedef struct packed {
        logic      branch;
        logic      used1;
        logic      used2;
        logic      rdy1;
        logic      rdy2;
        phys_tag_t rs1;
        phys_tag_t rs2;
        rob_id_t   rob;
    } uop_t;

    logic                cpu_clk_i = 1'b0;
    logic                rst_n_i;
    logic                flush_i;
    logic                p0_vld;
    logic                p1_vld;
    uop_t                p0_u;
    uop_t                p1_u;
    phys_tag_t           eu_tag [NUM_WAKE];
    logic [NUM_WAKE-1:0] eu_vld;
    logic                p0_busy_o;
    logic                p1_busy_o;
    logic                alu0_vld_o;
    phys_tag_t           alu0_rs1_o;
    phys_tag_t           alu0_rs2_o;
    rob_id_t             alu0_rob_o;
    logic                alu1_vld_o;
    phys_tag_t           alu1_rs1_o;
    phys_tag_t           alu1_rs2_o;
    rob_id_t             alu1_rob_o;

    // expected micro-ops still in the queue in age order.
    uop_t                exp_q [$];
    logic [2**ROB_W-1:0] blocked;
    logic [2**ROB_W-1:0] branch_rob;
    rob_id_t             rob_next;
    int                  seed;
    int                  err_cnt;
    int                  test_err;
    int                  test_cnt;
    int                  pass_cnt;

    always #50 cpu_clk_i = ~cpu_clk_i;

    int_issue_queue #(.DEPTH(DEPTH)) i_int_issue_queue (
        .cpu_clk_i    (cpu_clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .p0_vld_i     (p0_vld),
        .p0_branch_i  (p0_u.branch),
        .p0_rs1_tag_i (p0_u.rs1),
        .p0_rs2_tag_i (p0_u.rs2),
        .p0_rob_i     (p0_u.rob),
        .p0_rs1_vld_i (p0_u.used1),
        .p0_rs2_vld_i (p0_u.used2),
        .p0_rs1_rdy_i (p0_u.rdy1),
        .p0_rs2_rdy_i (p0_u.rdy2),
        .p1_vld_i     (p1_vld),
        .p1_branch_i  (p1_u.branch),
        .p1_rs1_tag_i (p1_u.rs1),
        .p1_rs2_tag_i (p1_u.rs2),
        .p1_rob_i     (p1_u.rob),
        .p1_rs1_vld_i (p1_u.used1),
        .p1_rs2_vld_i (p1_u.used2),
        .p1_rs1_rdy_i (p1_u.rdy1),
        .p1_rs2_rdy_i (p1_u.rdy2),
        .eu0_wk_i     (eu_tag[0]),
        .eu1_wk_i     (eu_tag[1]),
        .eu2_wk_i     (eu_tag[2]),
        .eu0_vld_i    (eu_vld[0]),
        .eu1_vld_i    (eu_vld[1]),
        .eu2_vld_i    (eu_vld[2]),
        .p0_busy_o    (p0_busy_o),
        .p1_busy_o    (p1_busy_o),
        .alu0_vld_o   (alu0_vld_o),
        .alu0_rs1_o   (alu0_rs1_o),
        .alu0_rs2_o   (alu0_rs2_o),
        .alu0_rob_o   (alu0_rob_o),
        .alu1_vld_o   (alu1_vld_o),
        .alu1_rs1_o   (alu1_rs1_o),
        .alu1_rs2_o   (alu1_rs2_o),
        .alu1_rob_o   (alu1_rob_o)
    );

    task automatic report_fail(input string msg);
        err_cnt++;
        $display("%s (at %0t)", msg, $time);
    endtask

    task automatic report_value(input string name, input phys_tag_t got, input phys_tag_t exp);
        err_cnt++;
        $display("ERROR %s got %h expected %h (at %0t)", name, got, exp, $time);
    endtask

    task automatic report_bit(input string name, input logic got, input logic exp);
        err_cnt++;
        $display("ERROR %s got %h expected %h (at %0t)", name, got, exp, $time);
    endtask

    // a full queue always has fewer than two free slots.
    assert property (@(negedge cpu_clk_i) disable iff (!rst_n_i) p0_busy_o |-> p1_busy_o)
        else report_fail("p0_busy_o is high while p1_busy_o is low");

    assert property (@(negedge cpu_clk_i) disable iff (!rst_n_i)
        alu1_vld_o |-> !branch_rob[alu1_rob_o])
        else report_fail("a branch was issued on alu1");

    assert property (@(negedge cpu_clk_i) disable iff (!rst_n_i)
        flush_i |=> (!alu0_vld_o && !alu1_vld_o && !p0_busy_o && !p1_busy_o))
        else report_fail("queue still busy or issuing right after a flush");

    assert property (@(negedge cpu_clk_i) !rst_n_i |=> (!alu0_vld_o && !alu1_vld_o))
        else report_fail("issue valid is high during reset");

    function automatic phys_tag_t rand_tag();
        return phys_tag_t'($random(seed));
    endfunction

    function automatic uop_t new_uop(input logic branch, input logic rdy1, input phys_tag_t rs1);
        uop_t u;
        u.branch = branch;
        u.used1  = 1'b1;
        u.used2  = 1'b1;
        u.rdy1   = rdy1;
        u.rdy2   = 1'b1;
        u.rs1    = rs1;
        u.rs2    = rand_tag();
        u.rob    = rob_next;
        rob_next++;
        branch_rob[u.rob] = branch;
        return u;
    endfunction

    function automatic logic holds_rob(input rob_id_t rob);
        foreach (exp_q[i]) begin
            if (exp_q[i].rob == rob) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic expect_uop(input uop_t u);
        exp_q.push_back(u);
        blocked[u.rob] = !((!u.used1 || u.rdy1) && (!u.used2 || u.rdy2));
    endtask

    task automatic drive_uops(input logic v0, input uop_t u0, input logic v1, input uop_t u1);
        @(posedge cpu_clk_i);
        p0_vld <= v0;
        p0_u   <= u0;
        p1_vld <= v1;
        p1_u   <= u1;
    endtask

    task automatic stop_dispatch();
        @(posedge cpu_clk_i);
        p0_vld <= 1'b0;
        p1_vld <= 1'b0;
    endtask

    task automatic pulse_flush();
        @(posedge cpu_clk_i);
        flush_i <= 1'b1;
        p0_vld  <= 1'b0;
        p1_vld  <= 1'b0;
        @(posedge cpu_clk_i);
        flush_i <= 1'b0;
    endtask

    // one-cycle wakeup strobe; waiting entries become legal to issue.
    task automatic strobe_tag(input int unit, input phys_tag_t tag);
        @(posedge cpu_clk_i);
        eu_tag[unit] <= tag;
        eu_vld[unit] <= 1'b1;
        foreach (exp_q[i]) begin
            if (exp_q[i].used1 && !exp_q[i].rdy1 && exp_q[i].rs1 == tag) begin
                blocked[exp_q[i].rob] = 1'b0;
            end
        end
        @(posedge cpu_clk_i);
        eu_vld[unit] <= 1'b0;
    endtask

    task automatic wait_issued(input rob_id_t rob, input int limit);
        int n;
        n = 0;
        while (holds_rob(rob) && n < limit) begin
            @(posedge cpu_clk_i);
            n++;
        end
        if (holds_rob(rob)) begin
            report_fail($sformatf("timed out waiting for ROB id %h to issue", rob));
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit) begin
            @(posedge cpu_clk_i);
            n++;
        end
        if (exp_q.size() != 0) begin
            report_fail($sformatf("timed out with %0d micro-ops never issued", exp_q.size()));
            exp_q.delete();
        end
    endtask

    task automatic check_busy(input int queued);
        logic exp0;
        logic exp1;
        exp0 = (queued >= DEPTH);
        exp1 = (queued >= DEPTH - 1);
        assert (p0_busy_o == exp0) else report_bit("p0_busy_o", p0_busy_o, exp0);
        assert (p1_busy_o == exp1) else report_bit("p1_busy_o", p1_busy_o, exp1);
    endtask

    task automatic check_issue(input string port, input rob_id_t rob,
                               input phys_tag_t rs1, input phys_tag_t rs2);
        int idx;
        idx = -1;
        foreach (exp_q[i]) begin
            if (idx < 0 && exp_q[i].rob == rob) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            report_fail($sformatf("%s issued ROB id %h, which is not in the queue", port, rob));
        end else begin
            assert (!blocked[rob])
                else report_fail($sformatf("ROB id %h issued before its wakeup", rob));
            assert (rs1 == exp_q[idx].rs1)
                else report_value({port, "_rs1_o"}, rs1, exp_q[idx].rs1);
            assert (rs2 == exp_q[idx].rs2)
                else report_value({port, "_rs2_o"}, rs2, exp_q[idx].rs2);
            exp_q.delete(idx);
        end
    endtask

    always @(negedge cpu_clk_i) begin
        if (rst_n_i) begin
            if (alu0_vld_o) begin
                check_issue("alu0", alu0_rob_o, alu0_rs1_o, alu0_rs2_o);
            end
            if (alu1_vld_o) begin
                check_issue("alu1", alu1_rob_o, alu1_rs1_o, alu1_rs2_o);
            end
        end
    end

    task automatic start_test();
        test_err = err_cnt;
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == test_err) begin
            pass_cnt++;
            $display("test %0d %s: passed", test_cnt, name);
        end else begin
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err);
        end
    endtask

    initial begin
        uop_t      ua;
        uop_t      ub;
        uop_t      uw [NUM_WAKE];
        phys_tag_t tags [NUM_WAKE];
        phys_tag_t tag;
        seed       = 54;
        err_cnt    = 0;
        test_cnt   = 0;
        pass_cnt   = 0;
        rob_next   = '0;
        blocked    = '0;
        branch_rob = '0;
        rst_n_i <= 1'b0;
        flush_i <= 1'b0;
        p0_vld  <= 1'b0;
        p1_vld  <= 1'b0;
        p0_u    <= '0;
        p1_u    <= '0;
        eu_vld  <= '0;
        for (int k = 0; k < NUM_WAKE; k++) begin
            eu_tag[k] <= '0;
        end
        repeat (4) @(posedge cpu_clk_i);
        rst_n_i <= 1'b1;

        start_test();
        @(negedge cpu_clk_i);
        assert (!alu0_vld_o) else report_bit("alu0_vld_o", alu0_vld_o, 1'b0);
        assert (!alu1_vld_o) else report_bit("alu1_vld_o", alu1_vld_o, 1'b0);
        check_busy(0);
        end_test("reset state");

        // rs2 unused, so only the ready rs1 matters.
        start_test();
        ua = new_uop(1'b0, 1'b1, rand_tag());
        ua.used2 = 1'b0;
        ua.rdy2  = 1'b0;
        expect_uop(ua);
        drive_uops(1'b1, ua, 1'b0, '0);
        stop_dispatch();
        @(negedge cpu_clk_i);
        assert (!alu0_vld_o) else report_bit("alu0_vld_o", alu0_vld_o, 1'b0);
        @(negedge cpu_clk_i);
        assert (alu0_vld_o) else report_bit("alu0_vld_o", alu0_vld_o, 1'b1);
        assert (alu0_rob_o == ua.rob) else report_value("alu0_rob_o", alu0_rob_o, ua.rob);
        wait_drain(WAIT_MAX);
        end_test("ready dispatch issues after one cycle");

        start_test();
        for (int k = 0; k < NUM_WAKE; k++) begin
            do begin
                tags[k] = rand_tag();
            end while ((k > 0 && tags[k] == tags[0]) || (k > 1 && tags[k] == tags[1]));
            uw[k] = new_uop(1'b0, 1'b0, tags[k]);
            expect_uop(uw[k]);
        end
        drive_uops(1'b1, uw[0], 1'b1, uw[1]);
        drive_uops(1'b1, uw[2], 1'b0, '0);
        stop_dispatch();
        repeat (6) @(posedge cpu_clk_i);
        for (int k = 0; k < NUM_WAKE; k++) begin
            strobe_tag(k, tags[k]);
            wait_issued(uw[k].rob, WAIT_MAX);
        end
        wait_drain(WAIT_MAX);
        end_test("wakeup on each bus");

        start_test();
        ua = new_uop(1'b0, 1'b1, rand_tag());
        ub = new_uop(1'b0, 1'b1, rand_tag());
        expect_uop(ua);
        expect_uop(ub);
        drive_uops(1'b1, ua, 1'b1, ub);
        stop_dispatch();
        @(negedge cpu_clk_i);
        @(negedge cpu_clk_i);
        assert (alu0_vld_o) else report_bit("alu0_vld_o", alu0_vld_o, 1'b1);
        assert (alu0_rob_o == ua.rob) else report_value("alu0_rob_o", alu0_rob_o, ua.rob);
        assert (alu1_vld_o) else report_bit("alu1_vld_o", alu1_vld_o, 1'b1);
        assert (alu1_rob_o == ub.rob) else report_value("alu1_rob_o", alu1_rob_o, ub.rob);
        wait_drain(WAIT_MAX);
        ua = new_uop(1'b1, 1'b1, rand_tag());
        ub = new_uop(1'b1, 1'b1, rand_tag());
        expect_uop(ua);
        expect_uop(ub);
        drive_uops(1'b1, ua, 1'b1, ub);
        stop_dispatch();
        wait_drain(WAIT_MAX);
        end_test("dual issue and branch rule");

        // fill every slot, then offer one more that must be dropped.
        start_test();
        tag = rand_tag();
        for (int k = 0; k < DEPTH; k++) begin
            ua = new_uop(1'b0, 1'b0, tag);
            expect_uop(ua);
            drive_uops(1'b1, ua, 1'b0, '0);
            @(negedge cpu_clk_i);
            check_busy(k);
        end
        ub = new_uop(1'b0, 1'b1, rand_tag());
        drive_uops(1'b1, ub, 1'b0, '0);
        @(negedge cpu_clk_i);
        check_busy(DEPTH);
        stop_dispatch();
        @(negedge cpu_clk_i);
        check_busy(DEPTH);
        strobe_tag(0, tag);
        wait_drain(WAIT_MAX);
        repeat (4) @(posedge cpu_clk_i);
        end_test("full queue and busy levels");

        // the queue is full when the flush lands; nothing flushed is expected.
        start_test();
        tag = rand_tag();
        for (int k = 0; k < DEPTH - 1; k++) begin
            ua = new_uop(1'b0, 1'b0, tag);
            drive_uops(1'b1, ua, 1'b0, '0);
        end
        ua = new_uop(1'b0, 1'b1, rand_tag());
        drive_uops(1'b1, ua, 1'b0, '0);
        pulse_flush();
        @(negedge cpu_clk_i);
        assert (!alu0_vld_o) else report_bit("alu0_vld_o", alu0_vld_o, 1'b0);
        assert (!alu1_vld_o) else report_bit("alu1_vld_o", alu1_vld_o, 1'b0);
        check_busy(0);
        strobe_tag(2, tag);
        repeat (8) @(posedge cpu_clk_i);
        end_test("flush");

        $display("%0d tests, %0d passed, %0d errors", test_cnt, pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
logic/iq_cfg_pkg.sv
logic/iq_types_pkg.sv
logic/wakeup_if.sv
logic/dispatch_if.sv
logic/iq_compact_ctrl.sv
logic/iq_src_capture.sv
logic/iq_entry_array.sv
logic/iq_issue_select.sv
logic/int_issue_queue.sv
tests/tb_int_issue_queue.sv

//--- run_sim.sh
#!/bin/sh
# build and run the issue queue testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_int_issue_queue

out=$(./obj_dir/Vtb_int_issue_queue)
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED"
